/* uvispace_cfg.svh */
`ifndef UVISPACE_CFG_SVH
`define UVISPACE_CFG_SVH

// ====================
// Camera side widths
// ====================
`define UVI_COLOR_W     12    // Bits per demosaiced colour component
`define UVI_PACK_BITS   5     // MSBs kept per colour in RGB555

// ====================
// Frame buffer and display
// ====================
`define UVI_WORD_W      16    // Frame-buffer write word
`define UVI_RATE_W      16    // Frames per window
`define UVI_EXPOSURE_W  16    // Exposure register width
`define UVI_NUM_DIGITS  6     // Seven-segment digits on the board

// Rate window in pixel clocks
// Short value keeps simulation fast, the top level parameter overrides it
`define UVI_TICK_CYCLES 1000

`endif

/* uvispace_pkg.sv */
`default_nettype none

`include "uvispace_cfg.svh"

package uvispace_pkg;

  // ====================
  // Pixel path types
  // ====================
  typedef logic [`UVI_COLOR_W-1:0] color_t;       // One colour component

  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
  } rgb_pixel_t;                                  // Red in the MSBs

  typedef logic [`UVI_WORD_W-1:0] fb_word_t;      // Frame-buffer write word

  // ====================
  // Status and display types
  // ====================
  typedef logic [`UVI_RATE_W-1:0]     rate_t;
  typedef logic [`UVI_EXPOSURE_W-1:0] exposure_t;

  typedef enum logic {
    VIEW_RGB555 = 1'b0,                           // Colour image to frame buffer
    VIEW_MASK   = 1'b1                            // Binary mask, widened to a byte
  } view_mode_t;

  typedef logic [6:0] seg_t;                      // gfedcba, active low

endpackage

`default_nettype wire

/* video_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Gated camera stream between capture, writer and rate meter
// Valids are single-cycle strobes, no back-pressure
interface video_stream_if
  import uvispace_pkg::*;
();

  rgb_pixel_t pixel;        // Demosaiced pixel
  logic       rgb_valid;    // One strobe per pixel
  logic       mask;         // Binary mask bit
  logic       mask_valid;   // One strobe per mask bit
  logic       frame_done;   // Pulse at end of an accepted frame

  modport source (
    output pixel, rgb_valid, mask, mask_valid, frame_done
  );

  modport sink (
    input pixel, rgb_valid, mask, mask_valid
  );

  modport monitor (
    input frame_done
  );

endinterface

`default_nettype wire

/* frame_capture_gate.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_capture_gate
  import uvispace_pkg::*;
(
  input  logic           ccd_pixel_clk,
  input  logic           reset,
  input  logic           start,        // Capture enable, sampled at frame start
  input  logic           frame_valid,  // High across a whole frame
  input  rgb_pixel_t     pixel,
  input  logic           rgb_valid,
  input  logic           mask,
  input  logic           mask_valid,
  video_stream_if.source stream
);

  // ====================
  // Sample stage
  // ====================
  logic       fval_q;         // Registered frame_valid
  logic       fval_d;         // One more cycle, edge detect only
  logic       start_q;
  logic       rgb_valid_q;
  logic       mask_valid_q;
  rgb_pixel_t pixel_q;
  logic       mask_q;

  logic       capturing;      // Inside an accepted frame
  logic       frame_rise;
  logic       frame_fall;
  logic       accept;         // Gate for this sample

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      fval_q       <= 1'b0;
      fval_d       <= 1'b0;
      start_q      <= 1'b0;
      rgb_valid_q  <= 1'b0;
      mask_valid_q <= 1'b0;
    end else begin
      fval_q       <= frame_valid;
      fval_d       <= fval_q;
      start_q      <= start;
      rgb_valid_q  <= rgb_valid;
      mask_valid_q <= mask_valid;
    end
  end

  // Payload, no reset needed
  always_ff @(posedge ccd_pixel_clk) begin
    pixel_q <= pixel;
    mask_q  <= mask;
  end

  // ====================
  // Frame gate
  // ====================
  assign frame_rise = fval_q & ~fval_d;
  assign frame_fall = ~fval_q & fval_d;

  // Start only decides at the rising edge, afterwards the frame runs to its end
  assign accept = fval_q & (frame_rise ? start_q : capturing);

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      capturing         <= 1'b0;
      stream.rgb_valid  <= 1'b0;
      stream.mask_valid <= 1'b0;
      stream.frame_done <= 1'b0;
    end else begin
      capturing         <= accept;
      stream.rgb_valid  <= rgb_valid_q & accept;   // Suppressed outside a frame
      stream.mask_valid <= mask_valid_q & accept;
      stream.frame_done <= frame_fall & capturing; // Only frames we took
    end
  end

  // Gated payload follows its valid by the same stage
  always_ff @(posedge ccd_pixel_clk) begin
    stream.pixel <= pixel_q;
    stream.mask  <= mask_q;
  end

endmodule

`default_nettype wire

/* frame_buffer_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uvispace_cfg.svh"

module frame_buffer_writer
  import uvispace_pkg::*;
(
  input  logic         ccd_pixel_clk,
  input  logic         reset,
  input  view_mode_t   view_mode,    // RGB555 or mask view
  video_stream_if.sink stream,
  output logic         fb_wr_en,     // One write per accepted item
  output fb_word_t     fb_wr_data
);

  localparam int HALF_W = `UVI_WORD_W / 2;

  fb_word_t rgb_word;
  fb_word_t mask_word;
  logic     sel_valid;              // Strobe of the selected source

  // ====================
  // Word packing
  // ====================
  // Zero pad bit, then top bits of each colour
  assign rgb_word = {
    1'b0,
    stream.pixel.red[`UVI_COLOR_W-1 -: `UVI_PACK_BITS],
    stream.pixel.green[`UVI_COLOR_W-1 -: `UVI_PACK_BITS],
    stream.pixel.blue[`UVI_COLOR_W-1 -: `UVI_PACK_BITS]
  };

  // Mask bit widened to a full byte, high byte zero
  assign mask_word = {{HALF_W{1'b0}}, {HALF_W{stream.mask}}};

  assign sel_valid = (view_mode == VIEW_MASK) ? stream.mask_valid : stream.rgb_valid;

  // ====================
  // Output register
  // ====================
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      fb_wr_en <= 1'b0;
    end else begin
      fb_wr_en <= sel_valid;
    end
  end

  // Data only moves with a write
  always_ff @(posedge ccd_pixel_clk) begin
    if (sel_valid) begin
      fb_wr_data <= (view_mode == VIEW_MASK) ? mask_word : rgb_word;
    end
  end

endmodule

`default_nettype wire

/* frame_rate_meter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uvispace_cfg.svh"

module frame_rate_meter
  import uvispace_pkg::*;
#(
  parameter int TICK_CYCLES = `UVI_TICK_CYCLES   // Window length in pixel clocks
) (
  input  logic            ccd_pixel_clk,
  input  logic            reset,
  video_stream_if.monitor stream,
  output rate_t           rate,       // Frames in the last window
  output logic            tick_led    // Toggles once per window
);

  localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

  logic [CNT_W-1:0] win_cnt;
  logic             tick;
  rate_t            frame_cnt;      // Running count in current window
  logic             cnt_full;

  // ====================
  // Window timer
  // ====================
  assign tick = (win_cnt == CNT_W'(TICK_CYCLES - 1));   // Last cycle of window

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      win_cnt <= '0;
    end else if (tick) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  // ====================
  // Frame counting
  // ====================
  assign cnt_full = &frame_cnt;     // Saturate, no wrap to small values

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      frame_cnt <= '0;
      rate      <= '0;
      tick_led  <= 1'b0;
    end else if (tick) begin
      rate      <= frame_cnt;
      // Pulse on the tick itself belongs to the new window
      frame_cnt <= stream.frame_done ? rate_t'(1) : '0;
      tick_led  <= ~tick_led;
    end else if (stream.frame_done && !cnt_full) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* seven_seg_display.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uvispace_cfg.svh"

module seven_seg_display
  import uvispace_pkg::*;
(
  input  logic      ccd_pixel_clk,
  input  logic      reset,
  input  logic      show_exposure,   // High shows exposure, low shows rate
  input  rate_t     rate,
  input  exposure_t exposure,
  output seg_t      hex0,            // Lowest nibble
  output seg_t      hex1,
  output seg_t      hex2,
  output seg_t      hex3,
  output seg_t      hex4,
  output seg_t      hex5             // Highest nibble
);

  localparam int DISP_W = `UVI_NUM_DIGITS * 4;
  localparam seg_t GLYPH_ZERO = 7'b1000000;

  logic [DISP_W-1:0] disp_value;

  // Hex glyph lookup, segments active low
  function automatic seg_t hex_glyph(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110;    // f
    endcase
  endfunction

  // Zero-extended to all digits
  assign disp_value = show_exposure ? DISP_W'(exposure) : DISP_W'(rate);

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      {hex5, hex4, hex3, hex2, hex1, hex0} <= {`UVI_NUM_DIGITS{GLYPH_ZERO}};
    end else begin
      hex0 <= hex_glyph(disp_value[3:0]);
      hex1 <= hex_glyph(disp_value[7:4]);
      hex2 <= hex_glyph(disp_value[11:8]);
      hex3 <= hex_glyph(disp_value[15:12]);
      hex4 <= hex_glyph(disp_value[19:16]);
      hex5 <= hex_glyph(disp_value[23:20]);
    end
  end

endmodule

`default_nettype wire

/* uvispace_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uvispace_cfg.svh"

module uvispace_capture_top
  import uvispace_pkg::*;
#(
  parameter int TICK_CYCLES = `UVI_TICK_CYCLES   // Rate window, board build sets 1 s
) (
  input  logic       ccd_pixel_clk,
  input  logic       reset,
  // Camera side
  input  logic       start,          // Capture enable switch
  input  logic       frame_valid,
  input  color_t     rgb_red,
  input  color_t     rgb_green,
  input  color_t     rgb_blue,
  input  logic       rgb_valid,
  input  logic       mask,
  input  logic       mask_valid,
  // Controls
  input  view_mode_t view_mode,
  input  logic       show_exposure,
  input  exposure_t  exposure,
  // Frame buffer write port
  output logic       fb_wr_en,
  output fb_word_t   fb_wr_data,
  // Board indicators
  output logic       tick_led,
  output seg_t       hex0,
  output seg_t       hex1,
  output seg_t       hex2,
  output seg_t       hex3,
  output seg_t       hex4,
  output seg_t       hex5
);

  rgb_pixel_t cam_pixel;
  rate_t      rate;          // Meter to display

  assign cam_pixel = '{red: rgb_red, green: rgb_green, blue: rgb_blue};

  video_stream_if stream_bus ();

  // ====================
  // Input side
  // ====================
  frame_capture_gate u_gate (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .start         (start),
    .frame_valid   (frame_valid),
    .pixel         (cam_pixel),
    .rgb_valid     (rgb_valid),
    .mask          (mask),
    .mask_valid    (mask_valid),
    .stream        (stream_bus.source)
  );

  // Packs the frame-buffer word
  frame_buffer_writer u_writer (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .view_mode     (view_mode),
    .stream        (stream_bus.sink),
    .fb_wr_en      (fb_wr_en),
    .fb_wr_data    (fb_wr_data)
  );

  // ====================
  // Output side
  // ====================
  frame_rate_meter #(
    .TICK_CYCLES (TICK_CYCLES)
  ) u_meter (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .stream        (stream_bus.monitor),
    .rate          (rate),
    .tick_led      (tick_led)
  );

  seven_seg_display u_display (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .show_exposure (show_exposure),
    .rate          (rate),
    .exposure      (exposure),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

endmodule

`default_nettype wire

/* uvispace_capture_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uvispace_cfg.svh"

module uvispace_capture_asserts
  import uvispace_pkg::*;
#(
  parameter int TICK_CYCLES = `UVI_TICK_CYCLES
) (
  input logic ccd_pixel_clk,
  input logic reset,
  input logic rgb_valid,
  input logic mask_valid,
  input logic fb_wr_en,
  input logic tick_led,
  input seg_t hex0, hex1, hex2, hex3, hex4, hex5
);

  localparam seg_t SEG_ZERO = 7'b1000000;   // Glyph 0

  int unsigned fail_count = 0;
  int unsigned win_cyc;                     // Own window position

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset || win_cyc == TICK_CYCLES - 1) win_cyc <= 0;
    else win_cyc <= win_cyc + 1;
  end

  // ====================
  // Properties
  // ====================
  write_has_source: assert property (@(posedge ccd_pixel_clk) disable iff (reset)
      fb_wr_en |-> $past(rgb_valid || mask_valid, 3))
    else begin
      $error("Frame-buffer write without an input valid three cycles earlier");
      fail_count++;
    end

  // Checked at release
  reset_outputs: assert property (@(posedge ccd_pixel_clk) $fell(reset) |->
      !fb_wr_en && !tick_led && {hex5, hex4, hex3, hex2, hex1, hex0} == {6{SEG_ZERO}})
    else begin
      $error("Outputs not in their reset state after reset");
      fail_count++;
    end

  led_at_tick: assert property (@(posedge ccd_pixel_clk) disable iff (reset)
      $changed(tick_led) |-> $past(win_cyc == TICK_CYCLES - 1))
    else begin
      $error("Tick LED changed outside a window tick");
      fail_count++;
    end

endmodule

bind uvispace_capture_top uvispace_capture_asserts #(
  .TICK_CYCLES (TICK_CYCLES)
) u_asserts (
  .ccd_pixel_clk (ccd_pixel_clk),
  .reset         (reset),
  .rgb_valid     (rgb_valid),
  .mask_valid    (mask_valid),
  .fb_wr_en      (fb_wr_en),
  .tick_led      (tick_led),
  .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
);

`default_nettype wire

/* tb_uvispace_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uvispace_cfg.svh"

module tb_uvispace_capture
  import uvispace_pkg::*;
();

  // Active-low glyphs 0..f, gfedcba
  localparam logic [6:0] GLYPH [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
    7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

  logic       ccd_pixel_clk;
  logic       reset;
  logic       start;
  logic       frame_valid;
  color_t     rgb_red;
  color_t     rgb_green;
  color_t     rgb_blue;
  logic       rgb_valid;
  logic       mask;
  logic       mask_valid;
  view_mode_t view_mode;
  logic       show_exposure;
  exposure_t  exposure;
  logic       fb_wr_en;
  fb_word_t   fb_wr_data;
  logic       tick_led;
  seg_t       hex0;
  seg_t       hex1;
  seg_t       hex2;
  seg_t       hex3;
  seg_t       hex4;
  seg_t       hex5;

  int       cycle = 0;          // Rising edges since time 0
  int       errors = 0;
  int       timeouts = 0;
  int       toggles = 0;        // tick_led changes seen
  int       snap;
  int       tick_at;            // Cycle of the window-opening tick
  logic     led_last = 1'b0;
  int       due_q[$];           // Cycle each write is due
  fb_word_t word_q[$];          // Word expected at that cycle

  uvispace_capture_top dut0 (.*);

  // ====================
  // Clock and monitors
  // ====================
  initial begin
    ccd_pixel_clk = 1'b0;
    forever #5 ccd_pixel_clk = ~ccd_pixel_clk;
  end

  always @(posedge ccd_pixel_clk) cycle <= cycle + 1;

  // Writes compared against the reference queue, mid-cycle
  always @(negedge ccd_pixel_clk) begin
    if (!reset && fb_wr_en) begin
      assert (due_q.size() != 0) else begin
        errors++;
        $display("FAIL %0t: unexpected write of %h", $time, fb_wr_data);
      end
      if (due_q.size() != 0) begin
        assert (due_q[0] == cycle && word_q[0] == fb_wr_data) else begin
          errors++;
          $display("FAIL %0t: write %h at cycle %0d, expected %h at cycle %0d",
                   $time, fb_wr_data, cycle, word_q[0], due_q[0]);
        end
        due_q.delete(0);
        word_q.delete(0);
      end
    end else begin
      assert (due_q.size() == 0 || due_q[0] >= cycle) else begin
        errors++;
        $display("Expected write for cycle %0d never happened", due_q[0]);
        due_q.delete(0);
        word_q.delete(0);
      end
    end
  end

  always @(negedge ccd_pixel_clk) begin
    if (!reset && tick_led != led_last) toggles++;
    led_last = tick_led;
  end

  // ====================
  // Stimulus helpers
  // ====================
  task automatic next_cycle();
    @(posedge ccd_pixel_clk);
    #1;                         // Drive just after the edge
  endtask

  // Prediction for the item driven this cycle
  task automatic expect_write();
    due_q.push_back(cycle + 3);
    if (view_mode == VIEW_MASK) begin
      word_q.push_back({8'h00, {8{mask}}});
    end else begin
      word_q.push_back({1'b0, rgb_red[11:7], rgb_green[11:7], rgb_blue[11:7]});
    end
  endtask

  // One frame of lines, start may flip after flip_at pixels
  task automatic send_frame(input int lines, input int line_len, input bit start_begin,
                            input int flip_at);
    int n;
    int px;
    n = 0;
    next_cycle();
    start       = start_begin;  // Sampled with the frame_valid rise
    frame_valid = 1'b1;
    for (int l = 0; l < lines; l++) begin
      repeat (2) next_cycle();  // Line blanking
      px = 0;
      while (px < line_len) begin
        if (n == flip_at) start = ~start_begin;
        rgb_valid  = ($urandom_range(3) != 0);   // Random gaps
        mask_valid = ($urandom_range(3) != 0);   // Own gaps, apart from the pixels
        rgb_red    = color_t'($urandom);
        rgb_green  = color_t'($urandom);
        rgb_blue   = color_t'($urandom);
        mask       = (($urandom & 1) != 0);
        // Only the stream of the current view produces writes
        if ((view_mode == VIEW_MASK) ? mask_valid : rgb_valid) begin
          if (start_begin) expect_write();       // Gate decided at frame start
          px++;
          n++;
        end
        next_cycle();
        rgb_valid  = 1'b0;
        mask_valid = 1'b0;
      end
    end
    frame_valid = 1'b0;
    repeat (4) next_cycle();
  endtask

  task automatic wait_writes_done();
    int n;
    n = 0;
    while (due_q.size() != 0 && n < 50) begin
      next_cycle();
      n++;
    end
    if (due_q.size() != 0) begin
      timeouts++;
      $display("Timeout: %0d expected writes still pending", due_q.size());
      due_q.delete();
      word_q.delete();
    end
    repeat (4) next_cycle();    // Room for stray writes
  endtask

  task automatic wait_tick();
    int   n;
    logic led0;
    n    = 0;
    led0 = tick_led;
    while (tick_led == led0 && n < 2 * `UVI_TICK_CYCLES) begin
      next_cycle();
      n++;
    end
    if (tick_led == led0) begin
      timeouts++;
      $display("Timeout: the tick LED never toggled");
    end
  endtask

  task automatic check_digits(input logic [23:0] value);
    logic [41:0] segs;
    segs = {hex5, hex4, hex3, hex2, hex1, hex0};
    for (int i = 0; i < 6; i++) begin
      assert (segs[i*7 +: 7] == GLYPH[value[i*4 +: 4]]) else begin
        errors++;
        $display("FAIL %0t: digit %0d shows %b, expected %b", $time, i,
                 segs[i*7 +: 7], GLYPH[value[i*4 +: 4]]);
      end
    end
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    void'($urandom(32'hc228_1ce4));
    reset         = 1'b1;
    start         = 1'b0;
    frame_valid   = 1'b0;
    rgb_red       = '0;
    rgb_green     = '0;
    rgb_blue      = '0;
    rgb_valid     = 1'b0;
    mask          = 1'b0;
    mask_valid    = 1'b0;
    view_mode     = VIEW_RGB555;
    show_exposure = 1'b0;
    exposure      = '0;
    repeat (10) next_cycle();
    reset = 1'b0;

    assert (!fb_wr_en && !tick_led) else begin
      errors++;
      $display("FAIL %0t: write enable or tick LED high after reset", $time);
    end
    check_digits(24'h0);

    send_frame(3, 8, 1'b1, -1);  // RGB555 words
    send_frame(2, 8, 1'b1, -1);
    wait_writes_done();
    view_mode = VIEW_MASK;       // Widened mask bytes
    send_frame(2, 8, 1'b1, -1);
    wait_writes_done();
    view_mode = VIEW_RGB555;
    send_frame(2, 8, 1'b0, 5);   // Late start, frame skipped
    send_frame(1, 8, 1'b1, -1);
    send_frame(2, 8, 1'b1, 4);   // Start dropped, frame still completes
    wait_writes_done();

    // Rate over one clean window
    wait_tick();
    tick_at = cycle;
    next_cycle();
    snap = toggles;
    send_frame(2, 6, 1'b1, -1);
    send_frame(1, 6, 1'b0, -1);  // Not accepted, not counted
    send_frame(2, 6, 1'b1, 3);
    wait_writes_done();
    wait_tick();
    assert (cycle - tick_at == `UVI_TICK_CYCLES) else begin
      errors++;
      $display("FAIL %0t: window lasted %0d cycles, expected %0d", $time,
               cycle - tick_at, `UVI_TICK_CYCLES);
    end
    next_cycle();
    assert (toggles == snap + 1) else begin
      errors++;
      $display("FAIL %0t: tick LED toggled %0d times in one window", $time, toggles - snap);
    end
    check_digits(24'd2);         // Two accepted frames in the window

    show_exposure = 1'b1;
    exposure      = exposure_t'($urandom);
    next_cycle();
    check_digits({8'h00, exposure});
    show_exposure = 1'b0;
    next_cycle();
    check_digits(24'd2);

    repeat (3) next_cycle();
    $display("Errors: %0d check, %0d timeout, %0d assertion", errors, timeouts,
             dut0.u_asserts.fail_count);
    if (errors + timeouts + dut0.u_asserts.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
uvispace_pkg.sv
video_stream_if.sv
frame_capture_gate.sv
frame_buffer_writer.sv
frame_rate_meter.sv
seven_seg_display.sv
uvispace_capture_top.sv
uvispace_capture_asserts.sv
tb_uvispace_capture.sv

/* Bender.yml */
package:
  name: uvispace_capture

sources:
  - include_dirs:
      - .
    files:
      - uvispace_pkg.sv
      - video_stream_if.sv
      - frame_capture_gate.sv
      - frame_buffer_writer.sv
      - frame_rate_meter.sv
      - seven_seg_display.sv
      - uvispace_capture_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - uvispace_capture_asserts.sv
      - tb_uvispace_capture.sv
